//--- source/execPkg.sv
//------------------------------------------------
// execute stage shared types
// word, opcode, condition and forwarding encodings
//------------------------------------------------
package execPkg;

   // one datapath word: operands, pc values, immediates, results
   typedef logic [15:0] dataWord;

   // alu operation select
   typedef logic [3:0] aluOpCode;

   // branch or set condition select
   typedef logic [2:0] brchCode;

   // forwarding control word
   // [4] store data select, [3] forward enable, [2] mem stage (1) or ex stage (0)
   // [1:0] source select
   typedef logic [4:0] fwdCtrl;

   // alu operations
   localparam aluOpCode opAdd   = 4'd0;
   localparam aluOpCode opAnd   = 4'd1;
   localparam aluOpCode opOr    = 4'd2;
   localparam aluOpCode opXor   = 4'd3;
   // shifts and rotates take the amount from the low 4 bits of b
   localparam aluOpCode opSll   = 4'd4;
   localparam aluOpCode opSrl   = 4'd5;
   localparam aluOpCode opRol   = 4'd6;
   localparam aluOpCode opRor   = 4'd7;
   localparam aluOpCode opPassB = 4'd8;
   // a shifted up a byte with the low byte of b
   localparam aluOpCode opSlbi  = 4'd9;

   // conditions on a + 0
   localparam brchCode brEqz = 3'd0;
   localparam brchCode brNez = 3'd1;
   localparam brchCode brLtz = 3'd2;
   localparam brchCode brGez = 3'd3;
   // conditions on a - b
   localparam brchCode brSeq = 3'd4;
   localparam brchCode brSlt = 3'd5;
   localparam brchCode brSle = 3'd6;
   // carry out of the add
   localparam brchCode brSco = 3'd7;

   // forwarding control bit positions
   localparam int fwdStoreBit = 4;
   localparam int fwdEnBit    = 3;
   localparam int fwdStageBit = 2;

   // forwarding sources
   localparam logic [1:0] fwdSrcAddPc = 2'd0;
   localparam logic [1:0] fwdSrcMem   = 2'd1;
   localparam logic [1:0] fwdSrcAlu   = 2'd2;
   localparam logic [1:0] fwdSrcImm   = 2'd3;

endpackage

//--- source/fwdBus.sv
//------------------------------------------------
// forwarding bus
// ex/mem and memory stage values offered to the operand selector
//------------------------------------------------
`timescale 1ns/1ps

interface fwdBus;

   // execute to execute, straight out of the ex/mem register
   execPkg::dataWord exAlu;
   execPkg::dataWord exImm;
   execPkg::dataWord exAddPc;

   // memory to execute
   execPkg::dataWord memAlu;
   execPkg::dataWord memImm;
   execPkg::dataWord memData;
   execPkg::dataWord memAddPc;

   modport exSide (output exAlu, exImm, exAddPc);

   modport memSide (output memAlu, memImm, memData, memAddPc);

   // operand selector only reads
   modport sel (
      input exAlu, exImm, exAddPc,
      input memAlu, memImm, memData, memAddPc
   );

endinterface

//--- source/operandFwd.sv
//------------------------------------------------
// operand selector
// register or forwarded values for a, b and store data
//------------------------------------------------
`timescale 1ns/1ps

module operandFwd (
   fwdBus.sel                fwd,
   input  execPkg::fwdCtrl   ctrlA,
   input  execPkg::fwdCtrl   ctrlB,
   input  execPkg::dataWord  regA,
   input  execPkg::dataWord  regB,
   input  logic              stuSel,
   input  execPkg::dataWord  storeIn,
   output execPkg::dataWord  opA,
   output execPkg::dataWord  opB,
   output execPkg::dataWord  storeData
);

   // source tables indexed by the low two control bits
   execPkg::dataWord memSrc [4];
   execPkg::dataWord exSrc  [4];
   execPkg::dataWord fwdB;

   assign memSrc[execPkg::fwdSrcAddPc] = fwd.memAddPc;
   assign memSrc[execPkg::fwdSrcMem]   = fwd.memData;
   assign memSrc[execPkg::fwdSrcAlu]   = fwd.memAlu;
   assign memSrc[execPkg::fwdSrcImm]   = fwd.memImm;

   assign exSrc[execPkg::fwdSrcAddPc]  = fwd.exAddPc;
   // no load data exists yet in ex/mem, fall back to its alu value
   assign exSrc[execPkg::fwdSrcMem]    = fwd.exAlu;
   assign exSrc[execPkg::fwdSrcAlu]    = fwd.exAlu;
   assign exSrc[execPkg::fwdSrcImm]    = fwd.exImm;

   // apply one control word to one register value
   function automatic execPkg::dataWord pickSrc(
      input execPkg::fwdCtrl  ctrl,
      input execPkg::dataWord regVal
   );
      if (!ctrl[execPkg::fwdEnBit])
         return regVal;
      else if (ctrl[execPkg::fwdStageBit])
         return memSrc[ctrl[1:0]];
      else
         return exSrc[ctrl[1:0]];
   endfunction

   always_comb begin
      opA  = pickSrc(ctrlA, regA);
      fwdB = pickSrc(ctrlB, regB);
   end

   // store with update uses b as the immediate path
   assign opB = stuSel ? regB : fwdB;

   // forwarded b only when store select and enable disagree
   assign storeData = (ctrlB[execPkg::fwdStoreBit] != ctrlB[execPkg::fwdEnBit]) ?
                      fwdB : storeIn;

endmodule

//--- source/aluCore.sv
//------------------------------------------------
// 16-bit alu
// logic, add, shifts, rotates and adder flags
//------------------------------------------------
`timescale 1ns/1ps

module aluCore (
   input  execPkg::dataWord  inA,
   input  execPkg::dataWord  inB,
   input  logic              cin,
   input  logic              invA,
   input  logic              invB,
   input  execPkg::aluOpCode op,
   output execPkg::dataWord  result,
   output logic              zero,
   output logic              ofl,
   output logic              cout,
   output logic              sign
);

   execPkg::dataWord a;
   execPkg::dataWord b;
   execPkg::dataWord sum;
   logic [3:0]       shamt;
   // doubled operand for rotates
   logic [31:0]      rolWide;
   logic [31:0]      rorWide;

   // optional inversion ahead of everything
   assign a = invA ? ~inA : inA;
   assign b = invB ? ~inB : inB;

   // subtraction is add with invB and cin
   assign {cout, sum} = {1'b0, a} + {1'b0, b} + {16'd0, cin};

   assign shamt   = b[3:0];
   assign rolWide = {a, a} << shamt;
   assign rorWide = {a, a} >> shamt;

   // flags always come from the adder path
   assign zero = (sum == '0);
   assign sign = sum[15];
   // signed overflow: like-signed inputs, result sign differs
   assign ofl  = (a[15] == b[15]) && (sum[15] != a[15]);

   always_comb begin
      case (op)
         execPkg::opAdd:
            result = sum;
         execPkg::opAnd:
            result = a & b;
         execPkg::opOr:
            result = a | b;
         execPkg::opXor:
            result = a ^ b;
         execPkg::opSll:
            result = a << shamt;
         execPkg::opSrl:
            result = a >> shamt;
         // upper half holds the bits that wrapped around
         execPkg::opRol:
            result = rolWide[31:16];
         execPkg::opRor:
            result = rorWide[15:0];
         execPkg::opPassB:
            result = b;
         execPkg::opSlbi:
            result = {a[7:0], b[7:0]};
         // unused codes behave like add
         default:
            result = sum;
      endcase
   end

endmodule

//--- source/branchCond.sv
//------------------------------------------------
// branch and set condition from alu flags
//------------------------------------------------
`timescale 1ns/1ps

module branchCond (
   input  execPkg::brchCode code,
   input  logic             zero,
   input  logic             ofl,
   input  logic             cout,
   input  logic             sign,
   output logic             taken
);

   // signed less than
   logic lessThan;

   assign lessThan = sign ^ ofl;

   always_comb begin
      case (code)
         execPkg::brEqz: taken = zero;
         execPkg::brNez: taken = ~zero;
         execPkg::brLtz: taken = lessThan;
         execPkg::brGez: taken = ~lessThan;
         execPkg::brSeq: taken = zero;
         execPkg::brSlt: taken = lessThan;
         execPkg::brSle: taken = lessThan | zero;
         execPkg::brSco: taken = cout;
         default:        taken = 1'b0;
      endcase
   end

endmodule

//--- source/claAdder16.sv
//------------------------------------------------
// 16-bit carry lookahead adder
// four 4-bit groups with a second lookahead level
//------------------------------------------------
`timescale 1ns/1ps

module claAdder16 (
   input  execPkg::dataWord a,
   input  execPkg::dataWord b,
   input  logic             cin,
   output execPkg::dataWord sum,
   output logic             cout
);

   execPkg::dataWord p;
   execPkg::dataWord g;
   execPkg::dataWord c;
   // group propagate, generate and carry in
   logic [3:0]       grpP;
   logic [3:0]       grpG;
   logic [4:0]       grpC;

   assign p = a ^ b;
   assign g = a & b;

   for (genvar i = 0; i < 4; i++) begin : gGroup
      localparam int B = 4 * i;

      assign grpP[i] = &p[B+3:B];
      assign grpG[i] = g[B+3] | (p[B+3] & g[B+2]) | (&p[B+3:B+2] & g[B+1]) |
                       (&p[B+3:B+1] & g[B]);

      // bit carries inside the group
      assign c[B]   = grpC[i];
      assign c[B+1] = g[B] | (p[B] & grpC[i]);
      assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (&p[B+1:B] & grpC[i]);
      assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (&p[B+2:B+1] & g[B]) |
                      (&p[B+2:B] & grpC[i]);
   end

   // second level across the groups
   assign grpC[0] = cin;
   assign grpC[1] = grpG[0] | (grpP[0] & cin);
   assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (&grpP[1:0] & cin);
   assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (&grpP[2:1] & grpG[0]) |
                    (&grpP[2:0] & cin);
   assign grpC[4] = grpG[3] | (grpP[3] & grpG[2]) | (&grpP[3:2] & grpG[1]) |
                    (&grpP[3:1] & grpG[0]) | (&grpP[3:0] & cin);

   assign sum  = p ^ c;
   assign cout = grpC[4];

endmodule

//--- source/execute.sv
//------------------------------------------------
// execute stage
// operands, alu, condition, branch target and pc choice
//------------------------------------------------
`timescale 1ns/1ps

module execute (
   input  logic              slbiSel,
   input  logic              immSrc,
   input  execPkg::aluOpCode aluOp,
   input  execPkg::brchCode  brchSig,
   input  logic              cin,
   input  logic              invA,
   input  logic              invB,
   input  logic              aluJmp,
   input  logic              jalSel,
   input  logic              setOpSel,
   input  logic              aluPc,
   input  logic              stuSel,
   input  execPkg::dataWord  incPc,
   input  execPkg::dataWord  imm8,
   input  execPkg::dataWord  imm11,
   input  execPkg::dataWord  regA,
   input  execPkg::dataWord  regB,
   input  execPkg::dataWord  storeIn,
   input  execPkg::fwdCtrl   ctrlA,
   input  execPkg::fwdCtrl   ctrlB,
   fwdBus.sel                fwd,
   output execPkg::dataWord  aluFinal,
   output execPkg::dataWord  newPc,
   output execPkg::dataWord  addPc,
   output execPkg::dataWord  storeData
);

   execPkg::dataWord opA;
   execPkg::dataWord opB;
   execPkg::dataWord aluOut;
   execPkg::dataWord targetBase;
   execPkg::dataWord targetImm;
   execPkg::dataWord target;
   execPkg::dataWord jmpPc;
   logic             zero;
   logic             ofl;
   logic             cout;
   logic             sign;
   logic             taken;

   operandFwd operandSel (
      .fwd(fwd), .ctrlA(ctrlA), .ctrlB(ctrlB), .regA(regA), .regB(regB),
      .stuSel(stuSel), .storeIn(storeIn), .opA(opA), .opB(opB), .storeData(storeData)
   );

   aluCore alu (
      .inA(opA), .inB(opB), .cin(cin), .invA(invA), .invB(invB), .op(aluOp),
      .result(aluOut), .zero(zero), .ofl(ofl), .cout(cout), .sign(sign)
   );

   branchCond cond (
      .code(brchSig), .zero(zero), .ofl(ofl), .cout(cout), .sign(sign), .taken(taken)
   );

   // jump register style targets use the alu result as base
   assign targetBase = aluPc ? aluOut : incPc;
   assign targetImm  = immSrc ? imm11 : imm8;

   // carry out of the target add is not needed
   claAdder16 targetAdd (
      .a(targetBase), .b(targetImm), .cin(1'b0), .sum(target), .cout()
   );

   assign jmpPc = taken ? target : incPc;

   // slbi wins over alu jumps, which win over conditional branches
   assign newPc = slbiSel ? incPc : (aluJmp ? aluOut : jmpPc);

   // link value for jal
   assign addPc = jalSel ? incPc : jmpPc;

   // set instructions write the condition bit
   assign aluFinal = setOpSel ? {15'd0, taken} : aluOut;

endmodule

//--- source/exMemReg.sv
//------------------------------------------------
// ex/mem pipeline register
// holds results under stall, feeds ex to ex forwarding
//------------------------------------------------
`timescale 1ns/1ps

module exMemReg (
   input  logic             clk,
   input  logic             rst,
   input  logic             stall,
   input  logic             inValid,
   input  execPkg::dataWord aluFinal,
   input  execPkg::dataWord newPc,
   input  execPkg::dataWord addPc,
   input  execPkg::dataWord storeData,
   input  execPkg::dataWord imm8,
   output logic             outValid,
   output execPkg::dataWord outAlu,
   output execPkg::dataWord outNewPc,
   output execPkg::dataWord outAddPc,
   output execPkg::dataWord outStore,
   fwdBus.exSide            fwd
);

   // immediate kept only for forwarding
   execPkg::dataWord immReg;

   always_ff @(posedge clk) begin
      if (rst) begin
         outValid <= 1'b0;
         outAlu   <= '0;
         outNewPc <= '0;
         outAddPc <= '0;
         outStore <= '0;
         immReg   <= '0;
      end else if (!stall) begin
         outValid <= inValid;
         outAlu   <= aluFinal;
         outNewPc <= newPc;
         outAddPc <= addPc;
         outStore <= storeData;
         immReg   <= imm8;
      end
   end

   // previous item is the ex to ex source
   assign fwd.exAlu   = outAlu;
   assign fwd.exImm   = immReg;
   assign fwd.exAddPc = outAddPc;

endmodule

//--- source/exStageTop.sv
//------------------------------------------------
// execute stage top
// execute logic plus the ex/mem register
//------------------------------------------------
`timescale 1ns/1ps

module exStageTop (
   input  logic             clk,
   input  logic             rst,
   input  logic             stall,
   input  logic             inValid,
   // decoded controls
   input  logic             slbiSel,
   input  logic             immSrc,
   input  logic [3:0]       aluOp,
   input  logic [2:0]       brchSig,
   input  logic             cin,
   input  logic             invA,
   input  logic             invB,
   input  logic             aluJmp,
   input  logic             jalSel,
   input  logic             setOpSel,
   input  logic             aluPc,
   input  logic             stuSel,
   // operands
   input  logic [15:0]      incPc,
   input  logic [15:0]      imm8,
   input  logic [15:0]      imm11,
   input  logic [15:0]      regA,
   input  logic [15:0]      regB,
   input  logic [15:0]      storeIn,
   // memory stage forwarding values
   input  logic [15:0]      memAlu,
   input  logic [15:0]      memImm,
   input  logic [15:0]      memData,
   input  logic [15:0]      memAddPc,
   input  logic [4:0]       ctrlA,
   input  logic [4:0]       ctrlB,
   output logic             outValid,
   output logic [15:0]      outAlu,
   output logic [15:0]      outNewPc,
   output logic [15:0]      outAddPc,
   output logic [15:0]      outStore
);

   execPkg::dataWord aluFinal;
   execPkg::dataWord newPc;
   execPkg::dataWord addPc;
   execPkg::dataWord storeData;

   fwdBus fwdIf ();

   // memory stage side of the bus comes straight from the ports
   assign fwdIf.memAlu   = memAlu;
   assign fwdIf.memImm   = memImm;
   assign fwdIf.memData  = memData;
   assign fwdIf.memAddPc = memAddPc;

   execute exec (
      .slbiSel(slbiSel), .immSrc(immSrc), .aluOp(aluOp), .brchSig(brchSig),
      .cin(cin), .invA(invA), .invB(invB), .aluJmp(aluJmp), .jalSel(jalSel),
      .setOpSel(setOpSel), .aluPc(aluPc), .stuSel(stuSel), .incPc(incPc),
      .imm8(imm8), .imm11(imm11), .regA(regA), .regB(regB), .storeIn(storeIn),
      .ctrlA(ctrlA), .ctrlB(ctrlB), .fwd(fwdIf.sel), .aluFinal(aluFinal),
      .newPc(newPc), .addPc(addPc), .storeData(storeData)
   );

   exMemReg exMem (
      .clk(clk), .rst(rst), .stall(stall), .inValid(inValid),
      .aluFinal(aluFinal), .newPc(newPc), .addPc(addPc), .storeData(storeData),
      .imm8(imm8), .outValid(outValid), .outAlu(outAlu), .outNewPc(outNewPc),
      .outAddPc(outAddPc), .outStore(outStore), .fwd(fwdIf.exSide)
   );

endmodule

//--- test/clockGen.sv
//------------------------------------------------
// testbench clock source, 4 ns period
//------------------------------------------------
`timescale 1ns/1ps

module clockGen (
   output logic clk
);

   initial clk = 1'b0;

   // half period of 2 ns
   always #2 clk = ~clk;

endmodule

//--- test/exStage_props.sv
//------------------------------------------------
// ex/mem register checks
// reset clearing, stall hold and valid tracking
//------------------------------------------------
`timescale 1ns/1ps

module exStageProps (
   input logic        clk,
   input logic        rst,
   input logic        stall,
   input logic        inValid,
   input logic        outValid,
   input logic [15:0] outAlu,
   input logic [15:0] outNewPc,
   input logic [15:0] outAddPc,
   input logic [15:0] outStore
);

   // low until the first edge so $past has real history
   logic seenEdge = 1'b0;

   always @(posedge clk) begin
      seenEdge <= 1'b1;
   end

   // one reset edge clears every registered output
   resetClears: assert property (@(posedge clk)
      seenEdge && $past(rst) |->
         !outValid && outAlu == 16'd0 && outNewPc == 16'd0 &&
         outAddPc == 16'd0 && outStore == 16'd0)
      else $error("registered outputs not cleared after a reset edge");

   // a stalled edge changes nothing
   stallHolds: assert property (@(posedge clk)
      seenEdge && !$past(rst) && $past(stall) |->
         $stable(outValid) && $stable(outAlu) && $stable(outNewPc) &&
         $stable(outAddPc) && $stable(outStore))
      else $error("registered outputs moved while stall was high");

   // valid is inValid one accepted edge later
   validFollows: assert property (@(posedge clk)
      seenEdge && !$past(rst) && !$past(stall) |-> outValid == $past(inValid))
      else $error("outValid does not follow inValid of the accepted edge");

   // outputs must be resolved once out of reset
   outputsKnown: assert property (@(posedge clk)
      seenEdge && !rst |->
         !$isunknown({outValid, outAlu, outNewPc, outAddPc, outStore}))
      else $error("registered outputs hold unknown bits");

endmodule

bind exStageTop exStageProps props (
   .clk(clk), .rst(rst), .stall(stall), .inValid(inValid), .outValid(outValid),
   .outAlu(outAlu), .outNewPc(outNewPc), .outAddPc(outAddPc), .outStore(outStore)
);

//--- test/exStageTb.sv
//------------------------------------------------
// execute stage testbench
// random items against a reference model with assertion checks
//------------------------------------------------
`timescale 1ns/1ps

module exStageTb;

   logic clk;
   logic rst;
   logic stall;
   logic inValid;
   logic slbiSel, immSrc, cin, invA, invB;
   logic aluJmp, jalSel, setOpSel, aluPc, stuSel;
   execPkg::aluOpCode aluOp;
   execPkg::brchCode  brchSig;
   execPkg::dataWord  incPc, imm8, imm11, regA, regB, storeIn;
   execPkg::dataWord  memAlu, memImm, memData, memAddPc;
   execPkg::fwdCtrl   ctrlA, ctrlB;
   logic              outValid;
   execPkg::dataWord  outAlu, outNewPc, outAddPc, outStore;

   // reference model state that mirrors ex/mem
   logic             expValid;
   execPkg::dataWord expAlu, expNewPc, expAddPc, expStore, expImm;

   int errCount = 0;
   int timeoutCount = 0;

   clockGen clkSrc (.clk(clk));

   exStageTop uut (
      .clk(clk), .rst(rst), .stall(stall), .inValid(inValid),
      .slbiSel(slbiSel), .immSrc(immSrc), .aluOp(aluOp), .brchSig(brchSig),
      .cin(cin), .invA(invA), .invB(invB), .aluJmp(aluJmp), .jalSel(jalSel),
      .setOpSel(setOpSel), .aluPc(aluPc), .stuSel(stuSel), .incPc(incPc),
      .imm8(imm8), .imm11(imm11), .regA(regA), .regB(regB), .storeIn(storeIn),
      .memAlu(memAlu), .memImm(memImm), .memData(memData), .memAddPc(memAddPc),
      .ctrlA(ctrlA), .ctrlB(ctrlB), .outValid(outValid), .outAlu(outAlu),
      .outNewPc(outNewPc), .outAddPc(outAddPc), .outStore(outStore)
   );

   // forwarding rule with the ex side taken from the model register
   function automatic execPkg::dataWord pickOperand(
      input execPkg::fwdCtrl  ctrl,
      input execPkg::dataWord regVal
   );
      if (!ctrl[execPkg::fwdEnBit])
         return regVal;
      if (ctrl[execPkg::fwdStageBit]) begin
         case (ctrl[1:0])
            execPkg::fwdSrcAddPc: return memAddPc;
            execPkg::fwdSrcMem:   return memData;
            execPkg::fwdSrcAlu:   return memAlu;
            default:              return memImm;
         endcase
      end
      case (ctrl[1:0])
         execPkg::fwdSrcAddPc: return expAddPc;
         execPkg::fwdSrcImm:   return expImm;
         // no load data in ex/mem yet
         default:              return expAlu;
      endcase
   endfunction

   function automatic execPkg::dataWord aluModel(
      input execPkg::dataWord  a,
      input execPkg::dataWord  b,
      input logic              c,
      input logic              ia,
      input logic              ib,
      input execPkg::aluOpCode op
   );
      execPkg::dataWord x;
      execPkg::dataWord y;
      int               n;
      x = ia ? ~a : a;
      y = ib ? ~b : b;
      n = int'(y[3:0]);
      case (op)
         execPkg::opAnd:   return x & y;
         execPkg::opOr:    return x | y;
         execPkg::opXor:   return x ^ y;
         execPkg::opSll:   return x << n;
         execPkg::opSrl:   return x >> n;
         // a rotate is two shifts merged
         execPkg::opRol:   return (x << n) | (x >> (16 - n));
         execPkg::opRor:   return (x >> n) | (x << (16 - n));
         execPkg::opPassB: return y;
         execPkg::opSlbi:  return (x << 8) | {8'd0, y[7:0]};
         default:          return x + y + {15'd0, c};
      endcase
   endfunction

   // condition from the exact signed and unsigned sums of the adder inputs
   function automatic logic condModel(
      input execPkg::brchCode  code,
      input execPkg::dataWord  a,
      input execPkg::dataWord  b,
      input logic              c,
      input logic              ia,
      input logic              ib
   );
      execPkg::dataWord x;
      execPkg::dataWord y;
      int               total;
      int               exact;
      logic             isZero;
      logic             isNeg;
      x = ia ? ~a : a;
      y = ib ? ~b : b;
      total = int'(x) + int'(y) + int'(c);
      exact = int'($signed(x)) + int'($signed(y)) + int'(c);
      isZero = (total % 65536 == 0);
      isNeg = (exact < 0);
      case (code)
         execPkg::brEqz, execPkg::brSeq: return isZero;
         execPkg::brNez:                 return !isZero;
         execPkg::brLtz, execPkg::brSlt: return isNeg;
         execPkg::brGez:                 return !isNeg;
         execPkg::brSle:                 return isNeg || isZero;
         default:                        return total > 65535;
      endcase
   endfunction

   // model of the whole stage plus the ex/mem register
   always @(posedge clk) begin : refModel
      execPkg::dataWord a;
      execPkg::dataWord fb;
      execPkg::dataWord b;
      execPkg::dataWord alu;
      execPkg::dataWord tgt;
      execPkg::dataWord jmp;
      logic             tk;
      a   = pickOperand(ctrlA, regA);
      fb  = pickOperand(ctrlB, regB);
      b   = stuSel ? regB : fb;
      alu = aluModel(a, b, cin, invA, invB, aluOp);
      tk  = condModel(brchSig, a, b, cin, invA, invB);
      tgt = (aluPc ? alu : incPc) + (immSrc ? imm11 : imm8);
      jmp = tk ? tgt : incPc;
      if (rst) begin
         expValid <= 1'b0;
         expAlu   <= '0;
         expNewPc <= '0;
         expAddPc <= '0;
         expStore <= '0;
         expImm   <= '0;
      end else if (!stall) begin
         expValid <= inValid;
         expAlu   <= setOpSel ? {15'd0, tk} : alu;
         expNewPc <= slbiSel ? incPc : (aluJmp ? alu : jmp);
         expAddPc <= jalSel ? incPc : jmp;
         expStore <= (ctrlB[execPkg::fwdStoreBit] ^ ctrlB[execPkg::fwdEnBit]) ? fb : storeIn;
         expImm   <= imm8;
      end
   end

   task automatic reportMismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
      errCount++;
      $display("error %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
   endtask

   checkValid: assert property (@(posedge clk) !rst |-> outValid == expValid)
      else reportMismatch("outValid", 16'($sampled(expValid)), 16'($sampled(outValid)));
   checkAlu: assert property (@(posedge clk) !rst |-> outAlu == expAlu)
      else reportMismatch("outAlu", $sampled(expAlu), $sampled(outAlu));
   checkNewPc: assert property (@(posedge clk) !rst |-> outNewPc == expNewPc)
      else reportMismatch("outNewPc", $sampled(expNewPc), $sampled(outNewPc));
   checkAddPc: assert property (@(posedge clk) !rst |-> outAddPc == expAddPc)
      else reportMismatch("outAddPc", $sampled(expAddPc), $sampled(outAddPc));
   checkStore: assert property (@(posedge clk) !rst |-> outStore == expStore)
      else reportMismatch("outStore", $sampled(expStore), $sampled(outStore));

   task automatic initInputs();
      rst = 1'b1;
      stall = 1'b0;
      inValid = 1'b0;
      {slbiSel, immSrc, cin, invA, invB} = '0;
      {aluJmp, jalSel, setOpSel, aluPc, stuSel} = '0;
      aluOp = '0;
      brchSig = '0;
      {incPc, imm8, imm11, regA, regB, storeIn} = '0;
      {memAlu, memImm, memData, memAddPc} = '0;
      ctrlA = '0;
      ctrlB = '0;
   endtask

   // one random item with forwarding and stall only when asked for
   task automatic randomItem(input bit fwdOn, input bit stallOn);
      execPkg::dataWord a;
      a = ($urandom_range(0, 7) == 0) ? 16'd0 : 16'($urandom);
      regA <= a;
      // equal operands now and then so eq and le codes hit zero
      regB <= ($urandom_range(0, 3) == 0) ? a : 16'($urandom);
      inValid  <= 1'($urandom);
      slbiSel  <= ($urandom_range(0, 7) == 0);
      immSrc   <= 1'($urandom);
      aluOp    <= 4'($urandom_range(0, 9));
      brchSig  <= 3'($urandom);
      cin      <= 1'($urandom);
      invA     <= 1'($urandom);
      invB     <= 1'($urandom);
      aluJmp   <= ($urandom_range(0, 3) == 0);
      jalSel   <= 1'($urandom);
      setOpSel <= ($urandom_range(0, 3) == 0);
      aluPc    <= 1'($urandom);
      stuSel   <= ($urandom_range(0, 3) == 0);
      incPc    <= 16'($urandom);
      imm8     <= 16'($urandom);
      imm11    <= 16'($urandom);
      storeIn  <= 16'($urandom);
      memAlu   <= 16'($urandom);
      memImm   <= 16'($urandom);
      memData  <= 16'($urandom);
      memAddPc <= 16'($urandom);
      // enable bit forced low when forwarding is off
      ctrlA <= fwdOn ? 5'($urandom) : {1'($urandom), 1'b0, 3'($urandom)};
      ctrlB <= fwdOn ? 5'($urandom) : {1'($urandom), 1'b0, 3'($urandom)};
      stall <= stallOn && ($urandom_range(0, 2) == 0);
   endtask

   initial begin : stimulus
      int i;
      int waitCount;
      void'($urandom(53862));
      initInputs();
      // reset over three rising edges
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      waitCount = 0;
      while (rst !== 1'b0 && waitCount < 10) begin
         @(posedge clk);
         waitCount++;
      end
      if (rst !== 1'b0) begin
         $display("timeout: reset never went low");
         timeoutCount++;
      end else begin
         // stalled edges right after reset keep the cleared outputs
         for (i = 0; i < 4; i++) begin
            @(posedge clk);
            randomItem(1'b0, 1'b0);
            stall <= 1'b1;
         end
         // register operands only
         for (i = 0; i < 150; i++) begin
            @(posedge clk);
            randomItem(1'b0, 1'b0);
         end
         // forwarding from both stages
         for (i = 0; i < 200; i++) begin
            @(posedge clk);
            randomItem(1'b1, 1'b0);
         end
         // stall bursts while inputs keep changing
         for (i = 0; i < 250; i++) begin
            @(posedge clk);
            randomItem(1'b1, 1'b1);
         end
         @(posedge clk);
         stall   <= 1'b0;
         inValid <= 1'b0;
         waitCount = 0;
         while (outValid !== 1'b0 && waitCount < 10) begin
            @(posedge clk);
            waitCount++;
         end
         if (outValid !== 1'b0) begin
            $display("timeout: outValid stayed high after the stage was drained");
            timeoutCount++;
         end
      end
      // let the last edge's checks finish
      @(negedge clk);
      $display("checks done, %0d mismatches, %0d timeouts", errCount, timeoutCount);
      if (errCount == 0 && timeoutCount == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- vlog.f
source/execPkg.sv
source/fwdBus.sv
source/operandFwd.sv
source/aluCore.sv
source/branchCond.sv
source/claAdder16.sv
source/execute.sv
source/exMemReg.sv
source/exStageTop.sv
test/clockGen.sv
test/exStage_props.sv
test/exStageTb.sv

//--- Makefile
# Verilator flow for the execute stage testbench
TOP := exStageTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f --Mdir obj_dir -o simv

# pass only when the simulation output holds the pass line
run: compile
	@out="$$(./obj_dir/simv)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
